/* hdl/alu_pkg.sv */
/*
 * ALU shared definitions
 * Widths, operation codes, result sources and the structs that
 * carry requests, control groups and byte-lane results
 */
`default_nettype none

package alu_pkg;

  // Datapath geometry
  localparam int unsigned XLEN      = 32;
  localparam int unsigned NUM_LANES = XLEN / 8;
  localparam int unsigned SHAMT_W   = 5;
  localparam int unsigned CPOP_W    = 6;

  // Logic unit subcodes, applied to b or to ~b
  localparam logic [1:0] LOGIC_AND = 2'd0;
  localparam logic [1:0] LOGIC_OR  = 2'd1;
  localparam logic [1:0] LOGIC_XOR = 2'd2;

  ////////////////////////////////////////
  // Operation codes
  ////////////////////////////////////////

  // 34 operations, so the code is 6 bits wide
  typedef enum logic [5:0] {
    // Base integer set
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
    // Branch compares, cmp output only
    ALU_EQ, ALU_NE, ALU_LT, ALU_LTU, ALU_GE, ALU_GEU,
    // Basic bit manipulation
    ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU,
    ALU_ANDN, ALU_ORN, ALU_XNOR, ALU_ROL, ALU_ROR,
    ALU_CPOP, ALU_ORC_B, ALU_REV8, ALU_SEXT_B, ALU_SEXT_H,
    // Single-bit operations
    ALU_BSET, ALU_BCLR, ALU_BINV, ALU_BEXT
  } alu_op_e;

  // Source of the registered result word
  typedef enum logic [3:0] {
    SEL_LOGIC, SEL_ADD, SEL_SLT, SEL_SHIFT,
    SEL_MIN, SEL_MAX, SEL_CPOP, SEL_ORC,
    SEL_REV8, SEL_SEXT_B, SEL_SEXT_H, SEL_BSET,
    SEL_BCLR, SEL_BINV, SEL_BEXT, SEL_NONE
  } res_sel_e;

  ////////////////////////////////////////
  // Data and control groups
  ////////////////////////////////////////

  // Operand a, seen whole by the arithmetic and per byte by the lanes
  typedef union packed {
    logic [XLEN-1:0]           word;
    logic [NUM_LANES-1:0][7:0] bytes;
  } alu_word_u;

  typedef struct packed {
    logic            valid;
    alu_op_e         op;
    alu_word_u       operand_a;
    logic [XLEN-1:0] operand_b;
  } alu_req_t;

  typedef struct packed {
    logic rotate;
    logic rshift;
    logic arithmetic;
    // Shift a lone one to build the single-bit mask
    logic operand_tieoff;
  } shift_ctrl_t;

  typedef struct packed {
    logic b_negate;
    logic cmp_signed;
  } arith_ctrl_t;

  typedef struct packed {
    logic [7:0] orc;
    logic [3:0] pop;
    logic [7:0] rev;
  } lane_out_t;

endpackage

`default_nettype wire

/* hdl/alu_decode.sv */
/*
 * ALU operation decoder
 * Splits the operation code into shifter, adder and result-select
 * controls and forwards operand a to the datapath
 */
`timescale 1ns/1ns
`default_nettype none

module alu_decode (
  input  alu_pkg::alu_req_t    req_i,
  output alu_pkg::shift_ctrl_t shift_ctrl_o,
  output alu_pkg::arith_ctrl_t arith_ctrl_o,
  output alu_pkg::res_sel_e    res_sel_o,
  output logic [1:0]           logic_op_o,
  output logic                 invert_b_o,
  output alu_pkg::alu_word_u   operand_a_o,
  output logic                 valid_o
);

  // Cleared for codes outside the operation list
  logic op_known;

  assign operand_a_o = req_i.operand_a;
  assign valid_o     = req_i.valid;

  always_comb begin
    // Defaults fit the plain add path
    shift_ctrl_o = '0;
    arith_ctrl_o = '0;
    res_sel_o    = alu_pkg::SEL_NONE;
    logic_op_o   = alu_pkg::LOGIC_AND;
    invert_b_o   = 1'b0;
    op_known     = 1'b1;

    unique case (req_i.op)
      alu_pkg::ALU_ADD: res_sel_o = alu_pkg::SEL_ADD;
      alu_pkg::ALU_SUB: begin
        res_sel_o             = alu_pkg::SEL_ADD;
        arith_ctrl_o.b_negate = 1'b1;
      end
      alu_pkg::ALU_AND: res_sel_o = alu_pkg::SEL_LOGIC;
      alu_pkg::ALU_OR: begin
        res_sel_o  = alu_pkg::SEL_LOGIC;
        logic_op_o = alu_pkg::LOGIC_OR;
      end
      alu_pkg::ALU_XOR: begin
        res_sel_o  = alu_pkg::SEL_LOGIC;
        logic_op_o = alu_pkg::LOGIC_XOR;
      end
      // Inverted-b logic forms
      alu_pkg::ALU_ANDN: begin
        res_sel_o  = alu_pkg::SEL_LOGIC;
        invert_b_o = 1'b1;
      end
      alu_pkg::ALU_ORN: begin
        res_sel_o  = alu_pkg::SEL_LOGIC;
        logic_op_o = alu_pkg::LOGIC_OR;
        invert_b_o = 1'b1;
      end
      alu_pkg::ALU_XNOR: begin
        res_sel_o  = alu_pkg::SEL_LOGIC;
        logic_op_o = alu_pkg::LOGIC_XOR;
        invert_b_o = 1'b1;
      end
      alu_pkg::ALU_SLT: begin
        res_sel_o               = alu_pkg::SEL_SLT;
        arith_ctrl_o.cmp_signed = 1'b1;
      end
      alu_pkg::ALU_SLTU: res_sel_o = alu_pkg::SEL_SLT;
      // Branch compares leave the result word alone
      alu_pkg::ALU_LT, alu_pkg::ALU_GE: arith_ctrl_o.cmp_signed = 1'b1;
      alu_pkg::ALU_EQ, alu_pkg::ALU_NE,
      alu_pkg::ALU_LTU, alu_pkg::ALU_GEU: ;
      alu_pkg::ALU_MIN: begin
        res_sel_o               = alu_pkg::SEL_MIN;
        arith_ctrl_o.cmp_signed = 1'b1;
      end
      alu_pkg::ALU_MINU: res_sel_o = alu_pkg::SEL_MIN;
      alu_pkg::ALU_MAX: begin
        res_sel_o               = alu_pkg::SEL_MAX;
        arith_ctrl_o.cmp_signed = 1'b1;
      end
      alu_pkg::ALU_MAXU: res_sel_o = alu_pkg::SEL_MAX;
      // Shifts and rotates
      alu_pkg::ALU_SLL: res_sel_o = alu_pkg::SEL_SHIFT;
      alu_pkg::ALU_SRL, alu_pkg::ALU_SRA, alu_pkg::ALU_ROR: begin
        res_sel_o               = alu_pkg::SEL_SHIFT;
        shift_ctrl_o.rshift     = 1'b1;
        shift_ctrl_o.arithmetic = (req_i.op != alu_pkg::ALU_SRL);
        shift_ctrl_o.rotate     = (req_i.op == alu_pkg::ALU_ROR);
      end
      alu_pkg::ALU_ROL: begin
        res_sel_o               = alu_pkg::SEL_SHIFT;
        shift_ctrl_o.arithmetic = 1'b1;
        shift_ctrl_o.rotate     = 1'b1;
      end
      // Byte-lane and extension results
      alu_pkg::ALU_CPOP:   res_sel_o = alu_pkg::SEL_CPOP;
      alu_pkg::ALU_ORC_B:  res_sel_o = alu_pkg::SEL_ORC;
      alu_pkg::ALU_REV8:   res_sel_o = alu_pkg::SEL_REV8;
      alu_pkg::ALU_SEXT_B: res_sel_o = alu_pkg::SEL_SEXT_B;
      alu_pkg::ALU_SEXT_H: res_sel_o = alu_pkg::SEL_SEXT_H;
      // Single-bit operations all use the one-hot mask
      alu_pkg::ALU_BSET, alu_pkg::ALU_BCLR,
      alu_pkg::ALU_BINV, alu_pkg::ALU_BEXT: begin
        shift_ctrl_o.operand_tieoff = 1'b1;
        unique case (req_i.op)
          alu_pkg::ALU_BSET: res_sel_o = alu_pkg::SEL_BSET;
          alu_pkg::ALU_BCLR: res_sel_o = alu_pkg::SEL_BCLR;
          alu_pkg::ALU_BINV: res_sel_o = alu_pkg::SEL_BINV;
          default:           res_sel_o = alu_pkg::SEL_BEXT;
        endcase
      end
      default: op_known = 1'b0;
    endcase
  end

  // A live request always carries a listed operation
  always_comb begin
    assert final (req_i.valid !== 1'b1 || op_known)
      else $error("alu_decode: unlisted operation code %0d", req_i.op);
  end

endmodule

`default_nettype wire

/* hdl/alu_byte_lane.sv */
/*
 * ALU byte lane
 * Or-combine and population count of one operand byte, plus the
 * byte from the mirrored position for byte reversal
 */
`timescale 1ns/1ns
`default_nettype none

module alu_byte_lane (
  input  logic [7:0]          byte_i,
  input  logic [7:0]          mirror_byte_i,
  output alu_pkg::lane_out_t  lane_o
);

  logic [3:0] pop;

  // Ones in this byte, 0 to 8
  always_comb begin
    pop = '0;
    for (int i = 0; i < 8; i++) begin
      pop = pop + 4'(byte_i[i]);
    end
  end

  // orc.b byte is all ones when any bit is set
  assign lane_o.orc = {8{|byte_i}};
  assign lane_o.pop = pop;
  // Byte from lane NUM_LANES-1-i lands here
  assign lane_o.rev = mirror_byte_i;

endmodule

`default_nettype wire

/* hdl/alu_shifter.sv */
/*
 * ALU funnel shifter
 * Shifts and rotates through a 64-bit funnel; with the tie-off
 * it builds the one-hot mask for bset, bclr, binv and bext
 */
`timescale 1ns/1ns
`default_nettype none

module alu_shifter (
  input  alu_pkg::shift_ctrl_t        ctrl_i,
  input  logic [alu_pkg::XLEN-1:0]    operand_a_i,
  input  logic [alu_pkg::XLEN-1:0]    operand_b_i,
  output logic [alu_pkg::XLEN-1:0]    shift_result_o,
  output logic [alu_pkg::XLEN-1:0]    bset_o,
  output logic [alu_pkg::XLEN-1:0]    bclr_o,
  output logic [alu_pkg::XLEN-1:0]    binv_o,
  output logic [alu_pkg::XLEN-1:0]    bext_o
);

  // One extra bit so a negated amount wraps over the full funnel
  logic [alu_pkg::SHAMT_W:0]     shamt;
  logic [alu_pkg::XLEN-1:0]      low_half;
  logic [alu_pkg::XLEN-1:0]      high_half;
  logic [2*alu_pkg::XLEN-1:0]    funnel;

  ////////////////////////////////////////
  // Funnel inputs
  ////////////////////////////////////////

  always_comb begin
    // Only the low bits of b count
    shamt = {1'b0, operand_b_i[alu_pkg::SHAMT_W-1:0]};
    // Right shift is a left rotate by the negated amount
    if (ctrl_i.rshift) begin
      shamt = -shamt;
    end

    low_half = ctrl_i.operand_tieoff ? alu_pkg::XLEN'(1) : operand_a_i;

    // Upper half supplies the bits that enter the result
    if (ctrl_i.operand_tieoff) begin
      high_half = '0;
    end else if (ctrl_i.arithmetic) begin
      high_half = ctrl_i.rotate ? operand_a_i : {alu_pkg::XLEN{operand_a_i[alu_pkg::XLEN-1]}};
    end else begin
      high_half = ctrl_i.rotate ? '1 : '0;
    end
  end

  // Six rotate stages, widest first
  always_comb begin
    funnel = {high_half, low_half};
    for (int s = alu_pkg::SHAMT_W; s >= 0; s--) begin
      if (shamt[s]) begin
        funnel = (funnel << (1 << s)) | (funnel >> (2 * alu_pkg::XLEN - (1 << s)));
      end
    end
  end

  assign shift_result_o = funnel[alu_pkg::XLEN-1:0];

  ////////////////////////////////////////
  // Single-bit results from the mask
  ////////////////////////////////////////

  assign bset_o = operand_a_i | shift_result_o;
  assign bclr_o = operand_a_i & ~shift_result_o;
  assign binv_o = operand_a_i ^ shift_result_o;
  // Selected bit moved down to bit 0
  assign bext_o = {{(alu_pkg::XLEN-1){1'b0}}, |(operand_a_i & shift_result_o)};

  // Mask generation relies on the decoder never mixing tie-off and rotate
  always_comb begin
    assert final (!(ctrl_i.operand_tieoff && ctrl_i.rotate))
      else $error("alu_shifter: tie-off together with rotate");
  end

endmodule

`default_nettype wire

/* hdl/alu_adder_cmp.sv */
/*
 * ALU adder and comparator
 * Add/subtract, signed or unsigned less-than, min/max words
 * and the branch compare bit
 */
`timescale 1ns/1ns
`default_nettype none

module alu_adder_cmp (
  input  alu_pkg::arith_ctrl_t      ctrl_i,
  input  alu_pkg::alu_op_e          op_i,
  input  logic [alu_pkg::XLEN-1:0]  operand_a_i,
  input  logic [alu_pkg::XLEN-1:0]  operand_b_i,
  output logic [alu_pkg::XLEN-1:0]  sum_o,
  output logic                      less_o,
  output logic [alu_pkg::XLEN-1:0]  min_o,
  output logic [alu_pkg::XLEN-1:0]  max_o,
  output logic                      cmp_o
);

  logic [alu_pkg::XLEN-1:0] adder_b;
  logic [alu_pkg::XLEN:0]   adder_sum;
  logic                     is_equal;

  ////////////////////////////////////////
  // Adder
  ////////////////////////////////////////

  assign adder_b = ctrl_i.b_negate ? ~operand_b_i : operand_b_i;
  // Carry enters through the extra low bit for two's complement
  assign adder_sum = {operand_a_i, 1'b1} + {adder_b, ctrl_i.b_negate};
  assign sum_o     = adder_sum[alu_pkg::XLEN:1];

  ////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////

  assign is_equal = (operand_a_i == operand_b_i);
  // Sign bit copied up only for signed compares
  assign less_o =
    $signed({operand_a_i[alu_pkg::XLEN-1] & ctrl_i.cmp_signed, operand_a_i}) <
    $signed({operand_b_i[alu_pkg::XLEN-1] & ctrl_i.cmp_signed, operand_b_i});

  assign min_o = less_o ? operand_a_i : operand_b_i;
  assign max_o = less_o ? operand_b_i : operand_a_i;

  always_comb begin
    unique case (op_i)
      alu_pkg::ALU_EQ:  cmp_o = is_equal;
      alu_pkg::ALU_NE:  cmp_o = !is_equal;
      alu_pkg::ALU_LT, alu_pkg::ALU_LTU,
      alu_pkg::ALU_SLT, alu_pkg::ALU_SLTU: cmp_o = less_o;
      alu_pkg::ALU_GE, alu_pkg::ALU_GEU:  cmp_o = !less_o;
      // Not a compare, flag stays low
      default: cmp_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/alu_result_stage.sv */
/*
 * ALU result stage
 * Drains the byte lanes, forms logic and extension results,
 * selects the result word and registers result, compare and valid
 */
`timescale 1ns/1ns
`default_nettype none

module alu_result_stage (
  input  logic                                          clk,
  input  logic                                          reset_i,
  input  logic                                          valid_i,
  input  alu_pkg::res_sel_e                             res_sel_i,
  input  logic [1:0]                                    logic_op_i,
  input  logic                                          invert_b_i,
  input  logic [alu_pkg::XLEN-1:0]                      operand_a_i,
  input  logic [alu_pkg::XLEN-1:0]                      operand_b_i,
  input  alu_pkg::lane_out_t [alu_pkg::NUM_LANES-1:0]   lanes_i,
  input  logic [alu_pkg::XLEN-1:0]                      shift_result_i,
  input  logic [alu_pkg::XLEN-1:0]                      bset_i,
  input  logic [alu_pkg::XLEN-1:0]                      bclr_i,
  input  logic [alu_pkg::XLEN-1:0]                      binv_i,
  input  logic [alu_pkg::XLEN-1:0]                      bext_i,
  input  logic [alu_pkg::XLEN-1:0]                      sum_i,
  input  logic                                          less_i,
  input  logic [alu_pkg::XLEN-1:0]                      min_i,
  input  logic [alu_pkg::XLEN-1:0]                      max_i,
  input  logic                                          cmp_i,
  output logic                                          valid_o,
  output logic [alu_pkg::XLEN-1:0]                      result_o,
  output logic                                          cmp_o
);

  logic [alu_pkg::CPOP_W-1:0] cpop;
  logic [alu_pkg::XLEN-1:0]   orc_word;
  logic [alu_pkg::XLEN-1:0]   rev_word;
  logic [alu_pkg::XLEN-1:0]   logic_b;
  logic [alu_pkg::XLEN-1:0]   logic_word;
  logic [alu_pkg::XLEN-1:0]   result_d;

  ////////////////////////////////////////
  // Lane drain
  ////////////////////////////////////////

  always_comb begin
    cpop     = '0;
    orc_word = '0;
    rev_word = '0;
    for (int i = 0; i < alu_pkg::NUM_LANES; i++) begin
      cpop              = cpop + alu_pkg::CPOP_W'(lanes_i[i].pop);
      orc_word[8*i +: 8] = lanes_i[i].orc;
      rev_word[8*i +: 8] = lanes_i[i].rev;
    end
  end

  // andn, orn and xnor reuse the plain gates on ~b
  assign logic_b = invert_b_i ? ~operand_b_i : operand_b_i;

  always_comb begin
    unique case (logic_op_i)
      alu_pkg::LOGIC_OR:  logic_word = operand_a_i | logic_b;
      alu_pkg::LOGIC_XOR: logic_word = operand_a_i ^ logic_b;
      default:            logic_word = operand_a_i & logic_b;
    endcase
  end

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  always_comb begin
    unique case (res_sel_i)
      alu_pkg::SEL_LOGIC:  result_d = logic_word;
      alu_pkg::SEL_ADD:    result_d = sum_i;
      alu_pkg::SEL_SLT:    result_d = {{(alu_pkg::XLEN-1){1'b0}}, less_i};
      alu_pkg::SEL_SHIFT:  result_d = shift_result_i;
      alu_pkg::SEL_MIN:    result_d = min_i;
      alu_pkg::SEL_MAX:    result_d = max_i;
      alu_pkg::SEL_CPOP:   result_d = alu_pkg::XLEN'(cpop);
      alu_pkg::SEL_ORC:    result_d = orc_word;
      alu_pkg::SEL_REV8:   result_d = rev_word;
      alu_pkg::SEL_SEXT_B: result_d = {{(alu_pkg::XLEN-8){operand_a_i[7]}}, operand_a_i[7:0]};
      alu_pkg::SEL_SEXT_H: result_d = {{(alu_pkg::XLEN-16){operand_a_i[15]}}, operand_a_i[15:0]};
      alu_pkg::SEL_BSET:   result_d = bset_i;
      alu_pkg::SEL_BCLR:   result_d = bclr_i;
      alu_pkg::SEL_BINV:   result_d = binv_i;
      alu_pkg::SEL_BEXT:   result_d = bext_i;
      // Branch-only operations write zero
      default:             result_d = '0;
    endcase
  end

  // Output register, holds its word between operations
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
      cmp_o    <= 1'b0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        result_o <= result_d;
        cmp_o    <= cmp_i;
      end
    end
  end

  // Downstream sees a clean valid once out of reset
  assert property (@(posedge clk) disable iff (reset_i) !$isunknown(valid_o))
    else $error("alu_result_stage: valid_o unknown");

  // Four lane counts never exceed the word width
  assert property (@(posedge clk) disable iff (reset_i)
                   valid_i |-> cpop <= alu_pkg::CPOP_W'(alu_pkg::XLEN))
    else $error("alu_result_stage: cpop %0d above word width", cpop);

endmodule

`default_nettype wire

/* hdl/alu_top.sv */
/*
 * Registered 32-bit integer ALU
 * Decoder, four byte lanes, shifter and adder/comparator
 * feeding a one-cycle result register
 */
`timescale 1ns/1ns
`default_nettype none

module alu_top (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic                      valid_i,
  input  alu_pkg::alu_op_e          op_i,
  input  logic [alu_pkg::XLEN-1:0]  operand_a_i,
  input  logic [alu_pkg::XLEN-1:0]  operand_b_i,
  output logic                      valid_o,
  output logic [alu_pkg::XLEN-1:0]  result_o,
  output logic                      cmp_o
);

  alu_pkg::alu_req_t                           req;
  alu_pkg::shift_ctrl_t                        shift_ctrl;
  alu_pkg::arith_ctrl_t                        arith_ctrl;
  alu_pkg::res_sel_e                           res_sel;
  logic [1:0]                                  logic_op;
  logic                                        invert_b;
  alu_pkg::alu_word_u                          operand_a;
  logic                                        dec_valid;
  alu_pkg::lane_out_t [alu_pkg::NUM_LANES-1:0] lanes;
  logic [alu_pkg::XLEN-1:0]                    shift_result;
  logic [alu_pkg::XLEN-1:0]                    bset;
  logic [alu_pkg::XLEN-1:0]                    bclr;
  logic [alu_pkg::XLEN-1:0]                    binv;
  logic [alu_pkg::XLEN-1:0]                    bext;
  logic [alu_pkg::XLEN-1:0]                    sum;
  logic                                        less;
  logic [alu_pkg::XLEN-1:0]                    min_word;
  logic [alu_pkg::XLEN-1:0]                    max_word;
  logic                                        cmp;

  assign req = '{valid: valid_i, op: op_i, operand_a: operand_a_i, operand_b: operand_b_i};

  alu_decode u_decode (
    .req_i        (req),
    .shift_ctrl_o (shift_ctrl),
    .arith_ctrl_o (arith_ctrl),
    .res_sel_o    (res_sel),
    .logic_op_o   (logic_op),
    .invert_b_o   (invert_b),
    .operand_a_o  (operand_a),
    .valid_o      (dec_valid)
  );

  // Lane i also carries byte NUM_LANES-1-i for rev8
  for (genvar i = 0; i < alu_pkg::NUM_LANES; i++) begin : gen_lane
    alu_byte_lane u_lane (
      .byte_i        (operand_a.bytes[i]),
      .mirror_byte_i (operand_a.bytes[alu_pkg::NUM_LANES-1-i]),
      .lane_o        (lanes[i])
    );
  end

  alu_shifter u_shifter (
    .ctrl_i         (shift_ctrl),
    .operand_a_i    (operand_a.word),
    .operand_b_i    (req.operand_b),
    .shift_result_o (shift_result),
    .bset_o         (bset),
    .bclr_o         (bclr),
    .binv_o         (binv),
    .bext_o         (bext)
  );

  alu_adder_cmp u_adder_cmp (
    .ctrl_i      (arith_ctrl),
    .op_i        (req.op),
    .operand_a_i (operand_a.word),
    .operand_b_i (req.operand_b),
    .sum_o       (sum),
    .less_o      (less),
    .min_o       (min_word),
    .max_o       (max_word),
    .cmp_o       (cmp)
  );

  alu_result_stage u_result_stage (
    .clk            (clk),
    .reset_i        (reset_i),
    .valid_i        (dec_valid),
    .res_sel_i      (res_sel),
    .logic_op_i     (logic_op),
    .invert_b_i     (invert_b),
    .operand_a_i    (operand_a.word),
    .operand_b_i    (req.operand_b),
    .lanes_i        (lanes),
    .shift_result_i (shift_result),
    .bset_i         (bset),
    .bclr_i         (bclr),
    .binv_i         (binv),
    .bext_i         (bext),
    .sum_i          (sum),
    .less_i         (less),
    .min_i          (min_word),
    .max_i          (max_word),
    .cmp_i          (cmp),
    .valid_o        (valid_o),
    .result_o       (result_o),
    .cmp_o          (cmp_o)
  );

endmodule

`default_nettype wire

/* tb/tb_alu_model.svh */
/*
 * ALU reference model
 * Expected result word and compare bit for each operation,
 * written from the instruction rules in plain arithmetic
 */
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// One expected response
typedef struct packed {
  logic [31:0] result;
  logic        cmp;
} expect_t;

function automatic expect_t model_alu(input alu_pkg::alu_op_e op,
                                      input logic [31:0] a,
                                      input logic [31:0] b);
  expect_t    res;
  logic [4:0] sh;
  logic       lt_s;
  logic       lt_u;
  sh   = b[4:0];
  lt_s = $signed(a) < $signed(b);
  lt_u = a < b;
  res  = '0;
  case (op)
    alu_pkg::ALU_ADD:  res.result = a + b;
    alu_pkg::ALU_SUB:  res.result = a - b;
    alu_pkg::ALU_AND:  res.result = a & b;
    alu_pkg::ALU_OR:   res.result = a | b;
    alu_pkg::ALU_XOR:  res.result = a ^ b;
    alu_pkg::ALU_SLT:  res.result = {31'd0, lt_s};
    alu_pkg::ALU_SLTU: res.result = {31'd0, lt_u};
    alu_pkg::ALU_SLL:  res.result = a << sh;
    alu_pkg::ALU_SRL:  res.result = a >> sh;
    alu_pkg::ALU_SRA:  res.result = $signed(a) >>> sh;
    alu_pkg::ALU_MIN:  res.result = lt_s ? a : b;
    alu_pkg::ALU_MINU: res.result = lt_u ? a : b;
    alu_pkg::ALU_MAX:  res.result = lt_s ? b : a;
    alu_pkg::ALU_MAXU: res.result = lt_u ? b : a;
    alu_pkg::ALU_ANDN: res.result = a & ~b;
    alu_pkg::ALU_ORN:  res.result = a | ~b;
    alu_pkg::ALU_XNOR: res.result = ~(a ^ b);
    // Shift by 32 gives zero, so amount 0 still works
    alu_pkg::ALU_ROL:  res.result = (a << sh) | (a >> (6'd32 - sh));
    alu_pkg::ALU_ROR:  res.result = (a >> sh) | (a << (6'd32 - sh));
    alu_pkg::ALU_CPOP: begin
      for (int i = 0; i < 32; i++) begin
        res.result = res.result + a[i];
      end
    end
    alu_pkg::ALU_ORC_B: begin
      for (int i = 0; i < 4; i++) begin
        res.result[8*i +: 8] = {8{|a[8*i +: 8]}};
      end
    end
    alu_pkg::ALU_REV8:   res.result = {a[7:0], a[15:8], a[23:16], a[31:24]};
    alu_pkg::ALU_SEXT_B: res.result = {{24{a[7]}}, a[7:0]};
    alu_pkg::ALU_SEXT_H: res.result = {{16{a[15]}}, a[15:0]};
    alu_pkg::ALU_BSET:   res.result = a | (32'd1 << sh);
    alu_pkg::ALU_BCLR:   res.result = a & ~(32'd1 << sh);
    alu_pkg::ALU_BINV:   res.result = a ^ (32'd1 << sh);
    alu_pkg::ALU_BEXT:   res.result = (a >> sh) & 32'd1;
    // Branch compares leave the word at zero
    default:             res.result = '0;
  endcase
  // Compare bit, set-less-than mirrors its result
  case (op)
    alu_pkg::ALU_EQ:                    res.cmp = (a == b);
    alu_pkg::ALU_NE:                    res.cmp = (a != b);
    alu_pkg::ALU_LT, alu_pkg::ALU_SLT:  res.cmp = lt_s;
    alu_pkg::ALU_LTU, alu_pkg::ALU_SLTU: res.cmp = lt_u;
    alu_pkg::ALU_GE:                    res.cmp = !lt_s;
    alu_pkg::ALU_GEU:                   res.cmp = !lt_u;
    default:                            res.cmp = 1'b0;
  endcase
  return res;
endfunction

`endif

/* tb/tb_alu.sv */
/*
 * Testbench for the registered ALU
 * Directed edge vectors, shift sweeps and random traffic,
 * checked by concurrent assertions against the reference model
 */
`timescale 1ns/1ns
`default_nettype none

module tb_alu;

  localparam int unsigned CLK_PERIOD   = 20;
  localparam int unsigned RESET_CYCLES = 3;
  localparam int unsigned NUM_OPS      = 34;
  localparam int unsigned RANDOM_OPS   = 2000;
  // Edge pairs, shift sweeps, byte words, sign pairs
  localparam int unsigned DIRECTED_OPS = NUM_OPS * 16 + 9 * 32 + 3 * 4 + 6 * 4;
  localparam int unsigned WATCHDOG_NS  = (DIRECTED_OPS + RANDOM_OPS + 50) * CLK_PERIOD;

  `include "tb_alu_model.svh"

  logic              clk;
  logic              reset_i;
  logic              valid_i;
  alu_pkg::alu_op_e  op_i;
  logic [31:0]       operand_a_i;
  logic [31:0]       operand_b_i;
  logic              valid_o;
  logic [31:0]       result_o;
  logic              cmp_o;

  // Expected responses, one entry per accepted request
  expect_t           exp_q[$];
  expect_t           head;
  logic              exp_valid;
  logic [31:0]       exp_result;
  logic              exp_cmp;
  int unsigned       requests_sent;
  int unsigned       results_seen;

  logic [31:0]       edge_vals [4] = '{32'h8000_0000, 32'h7fff_ffff, 32'h0, 32'hffff_ffff};
  logic [31:0]       byte_words [4] = '{32'h00ff_0000, 32'h1200_3400, 32'h0102_0408,
                                        32'h8000_0001};
  alu_pkg::alu_op_e  shift_ops [9] = '{alu_pkg::ALU_SLL, alu_pkg::ALU_SRL, alu_pkg::ALU_SRA,
                                       alu_pkg::ALU_ROL, alu_pkg::ALU_ROR, alu_pkg::ALU_BSET,
                                       alu_pkg::ALU_BCLR, alu_pkg::ALU_BINV, alu_pkg::ALU_BEXT};
  alu_pkg::alu_op_e  byte_ops [3] = '{alu_pkg::ALU_CPOP, alu_pkg::ALU_ORC_B, alu_pkg::ALU_REV8};
  alu_pkg::alu_op_e  branch_ops [6] = '{alu_pkg::ALU_EQ, alu_pkg::ALU_NE, alu_pkg::ALU_LT,
                                        alu_pkg::ALU_LTU, alu_pkg::ALU_GE, alu_pkg::ALU_GEU};

  alu_top u_dut (
    .clk         (clk),
    .reset_i     (reset_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .cmp_o       (cmp_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  // One request per rising edge
  task automatic send(input logic v, input alu_pkg::alu_op_e op,
                      input logic [31:0] a, input logic [31:0] b);
    @(posedge clk);
    valid_i     <= v;
    op_i        <= op;
    operand_a_i <= a;
    operand_b_i <= b;
  endtask

  ////////////////////////////////////////
  // Expected output register
  ////////////////////////////////////////

  // Mirrors the one-cycle latency, holding the word when idle
  always @(posedge clk) begin
    if (reset_i) begin
      exp_valid  <= 1'b0;
      exp_result <= '0;
      exp_cmp    <= 1'b0;
      exp_q.delete();
    end else begin
      if (valid_o) begin
        results_seen++;
      end
      exp_valid <= valid_i;
      if (valid_i) begin
        exp_q.push_back(model_alu(op_i, operand_a_i, operand_b_i));
        requests_sent++;
      end
      if (exp_q.size() != 0) begin
        head = exp_q.pop_front();
        exp_result <= head.result;
        exp_cmp    <= head.cmp;
      end
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  a_reset_values: assert property (@(posedge clk) $past(reset_i) |->
      (valid_o === 1'b0 && result_o === 32'h0 && cmp_o === 1'b0))
    else abort_run($sformatf("[FAIL] %0t: outputs not cleared by reset", $time));

  a_valid: assert property (@(posedge clk) disable iff (reset_i) valid_o === exp_valid)
    else abort_run($sformatf("[FAIL] %0t: valid_o %b, expected %b", $time,
                             $sampled(valid_o), $sampled(exp_valid)));

  a_result: assert property (@(posedge clk) disable iff (reset_i) result_o === exp_result)
    else abort_run($sformatf("[FAIL] %0t: result_o %h, expected %h", $time,
                             $sampled(result_o), $sampled(exp_result)));

  a_cmp: assert property (@(posedge clk) disable iff (reset_i) cmp_o === exp_cmp)
    else abort_run($sformatf("[FAIL] %0t: cmp_o %b, expected %b", $time,
                             $sampled(cmp_o), $sampled(exp_cmp)));

  initial begin
    #(WATCHDOG_NS);
    abort_run($sformatf("Timeout: run still going after %0d ns", WATCHDOG_NS));
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic        v;
    void'($urandom(32'hc42c0cf6));
    requests_sent = 0;
    results_seen  = 0;
    reset_i       = 1'b1;
    valid_i       = 1'b0;
    op_i          = alu_pkg::ALU_ADD;
    operand_a_i   = '0;
    operand_b_i   = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_i <= 1'b0;

    // Every operation over all edge operand pairs
    for (int k = 0; k < NUM_OPS; k++) begin
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          send(1'b1, alu_pkg::alu_op_e'(k), edge_vals[i], edge_vals[j]);
        end
      end
    end

    // Every shift amount, upper b bits random
    for (int k = 0; k < 9; k++) begin
      for (int sh = 0; sh < 32; sh++) begin
        r = $urandom();
        send(1'b1, shift_ops[k], $urandom(), {r[31:5], 5'(sh)});
      end
    end

    // Zero bytes mixed with set bytes
    for (int k = 0; k < 3; k++) begin
      for (int i = 0; i < 4; i++) begin
        send(1'b1, byte_ops[k], byte_words[i], $urandom());
      end
    end

    // Equal operands and operands apart only in sign
    for (int k = 0; k < 6; k++) begin
      r = $urandom();
      send(1'b1, branch_ops[k], 32'h0000_0005, 32'h8000_0005);
      send(1'b1, branch_ops[k], 32'h8000_0005, 32'h0000_0005);
      send(1'b1, branch_ops[k], r, r);
      send(1'b1, branch_ops[k], 32'hffff_fffe, 32'h7fff_fffe);
    end

    // Random traffic with gaps
    for (int n = 0; n < RANDOM_OPS; n++) begin
      a = ($urandom_range(3) == 0) ? edge_vals[$urandom_range(3)] : $urandom();
      b = ($urandom_range(3) == 0) ? edge_vals[$urandom_range(3)] : $urandom();
      if ($urandom_range(7) == 0) begin
        b = a;
      end
      v = ($urandom_range(99) < 80);
      send(v, alu_pkg::alu_op_e'($urandom_range(NUM_OPS - 1)), a, b);
    end

    send(1'b0, alu_pkg::ALU_ADD, '0, '0);
    repeat (3) @(posedge clk);

    if (exp_q.size() != 0 || results_seen != requests_sent) begin
      abort_run($sformatf("Result count %0d does not match request count %0d",
                          results_seen, requests_sent));
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+tb
hdl/alu_pkg.sv
hdl/alu_decode.sv
hdl/alu_byte_lane.sv
hdl/alu_shifter.sv
hdl/alu_adder_cmp.sv
hdl/alu_result_stage.sv
hdl/alu_top.sv
tb/tb_alu.sv

/* Bender.yml */
package:
  name: alu

sources:
  - hdl/alu_pkg.sv
  - hdl/alu_decode.sv
  - hdl/alu_byte_lane.sv
  - hdl/alu_shifter.sv
  - hdl/alu_adder_cmp.sv
  - hdl/alu_result_stage.sv
  - hdl/alu_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_alu.sv
